// File: verilog/alu_pkg.sv
package alu_pkg;

    localparam int data_w  = 8;                         // datapath width
    localparam int nib_w   = 4;                         // bcd digit width
    localparam int flags_w = 4;                         // status vector width

    // bit positions inside the status vector
    localparam int flag_n = 3;                          // negative
    localparam int flag_v = 2;                          // overflow
    localparam int flag_z = 1;                          // zero
    localparam int flag_c = 0;                          // carry, also not-borrow

    // decimal correction constants
    localparam logic [nib_w-1:0] bcd_max = 4'd9;        // largest valid digit
    localparam logic [nib_w-1:0] bcd_adj = 4'd6;        // skip over a..f

    typedef enum logic [3:0] {
        op_lda     = 4'h0,                              // acc <= db
        op_adc     = 4'h1,                              // acc <= acc + db + c
        op_sbc     = 4'h2,                              // acc <= acc - db - !c
        op_adc_adl = 4'h3,                              // acc <= acc + adl + c
        op_and     = 4'h4,                              // acc <= acc & db
        op_ora     = 4'h5,                              // acc <= acc | db
        op_eor     = 4'h6,                              // acc <= acc ^ db
        op_lsr     = 4'h7,                              // acc >> 1, bit 0 into c
        op_ror     = 4'h8,                              // rotate right through c
        op_cmp     = 4'h9                               // flags from acc - db
    } alu_op_t;

endpackage

// File: verilog/alu_ctrl_if.sv
interface alu_ctrl_if;

    logic ldb_inv_db, ldb_db, ldb_adl;                  // b operand selects
    logic lda_sb, lda_zero;                             // a operand selects
    logic enable_dec, carry_in;                         // bcd mode and carry
    logic e_sum, e_and, e_eor, e_or, e_shiftr;          // function strobes
    logic acc_we, upd_nz, upd_c, upd_v;                 // register updates
    logic op_done;                                      // operation issued

    modport decoder (
        output ldb_inv_db, ldb_db, ldb_adl, lda_sb, lda_zero,
        output enable_dec, carry_in,
        output e_sum, e_and, e_eor, e_or, e_shiftr,
        output acc_we, upd_nz, upd_c, upd_v, op_done
    );

    modport alu (
        input ldb_inv_db, ldb_db, ldb_adl, lda_sb, lda_zero,
        input enable_dec, carry_in,
        input e_sum, e_and, e_eor, e_or, e_shiftr
    );

    modport regs (
        input acc_we, upd_nz, upd_c, upd_v, op_done
    );

endinterface

// File: verilog/alu_decoder.sv
module alu_decoder (
    input  alu_pkg::alu_op_t op,
    input  logic             op_valid,
    input  logic             d_flag,
    input  logic             c_flag,
    alu_ctrl_if.decoder      ctrl
);
    import alu_pkg::*;

    always_comb begin
        ctrl.ldb_inv_db = 1'b0;                         // everything idle by default
        ctrl.ldb_db     = 1'b0;
        ctrl.ldb_adl    = 1'b0;
        ctrl.lda_sb     = 1'b0;
        ctrl.lda_zero   = 1'b0;
        ctrl.enable_dec = 1'b0;
        ctrl.carry_in   = 1'b0;
        ctrl.e_sum      = 1'b0;
        ctrl.e_and      = 1'b0;
        ctrl.e_eor      = 1'b0;
        ctrl.e_or       = 1'b0;
        ctrl.e_shiftr   = 1'b0;
        ctrl.acc_we     = 1'b0;
        ctrl.upd_nz     = 1'b0;
        ctrl.upd_c      = 1'b0;
        ctrl.upd_v      = 1'b0;
        ctrl.op_done    = 1'b0;

        if (op_valid) begin
            ctrl.op_done = 1'b1;
            ctrl.upd_nz  = 1'b1;
            ctrl.acc_we  = 1'b1;                        // cmp clears it below
            ctrl.lda_sb  = 1'b1;                        // a = acc on sb
            ctrl.ldb_db  = 1'b1;                        // b = db unless overridden

            case (op)
                op_lda: begin
                    ctrl.lda_sb   = 1'b0;
                    ctrl.lda_zero = 1'b1;               // 0 | db passes db through
                    ctrl.e_or     = 1'b1;
                end
                op_adc: begin
                    ctrl.e_sum      = 1'b1;
                    ctrl.carry_in   = c_flag;
                    ctrl.enable_dec = d_flag;
                    ctrl.upd_c      = 1'b1;
                    ctrl.upd_v      = !d_flag;          // v untouched in bcd mode
                end
                op_sbc: begin
                    ctrl.ldb_db     = 1'b0;
                    ctrl.ldb_inv_db = 1'b1;
                    ctrl.e_sum      = 1'b1;
                    ctrl.carry_in   = c_flag;
                    ctrl.enable_dec = d_flag;
                    ctrl.upd_c      = 1'b1;
                    ctrl.upd_v      = !d_flag;
                end
                op_adc_adl: begin
                    ctrl.ldb_db   = 1'b0;
                    ctrl.ldb_adl  = 1'b1;
                    ctrl.e_sum    = 1'b1;
                    ctrl.carry_in = c_flag;
                    ctrl.upd_c    = 1'b1;
                    ctrl.upd_v    = 1'b1;
                end
                op_and: ctrl.e_and = 1'b1;
                op_ora: ctrl.e_or  = 1'b1;
                op_eor: ctrl.e_eor = 1'b1;
                op_lsr: begin
                    ctrl.e_shiftr = 1'b1;               // zero shifted into bit 7
                    ctrl.upd_c    = 1'b1;
                end
                op_ror: begin
                    ctrl.e_shiftr = 1'b1;
                    ctrl.carry_in = c_flag;
                    ctrl.upd_c    = 1'b1;
                end
                op_cmp: begin
                    ctrl.ldb_db     = 1'b0;
                    ctrl.ldb_inv_db = 1'b1;
                    ctrl.e_sum      = 1'b1;
                    ctrl.carry_in   = 1'b1;             // plain subtract, no borrow in
                    ctrl.acc_we     = 1'b0;
                    ctrl.upd_c      = 1'b1;
                end
                default: begin
                    ctrl.acc_we = 1'b0;                 // unknown code changes nothing
                    ctrl.upd_nz = 1'b0;
                end
            endcase
        end
    end

    // the alu result mux relies on a single function being chosen
    always_comb begin
        assert ($onehot0({ctrl.e_sum, ctrl.e_and, ctrl.e_eor, ctrl.e_or, ctrl.e_shiftr}))
            else $error("alu_decoder: more than one function strobe for op %0d", op);
    end

endmodule

// File: verilog/alu.sv
module alu (
    input  logic                       clk,
    alu_ctrl_if.alu                    ctrl,
    input  logic [alu_pkg::data_w-1:0] db_in,
    input  logic [alu_pkg::data_w-1:0] adl_in,
    input  logic [alu_pkg::data_w-1:0] sb_in,
    output logic [alu_pkg::data_w-1:0] alu_out,
    output logic                       carry_out,
    output logic                       overflow
);
    import alu_pkg::*;

    logic [data_w-1:0] a, b;                            // operands
    logic [data_w:0]   bin_sum;                         // carry in top bit
    logic [nib_w:0]    lo_raw, hi_raw;                  // raw digit sums
    logic [nib_w-1:0]  lo_adj, hi_adj;                  // corrected digits
    logic              lo_carry, dec_carry;
    logic              dec_sub;

    assign a = (ctrl.lda_sb && !ctrl.lda_zero) ? sb_in : '0;

    always_comb begin
        if (ctrl.ldb_adl) begin
            b = adl_in;
        end else if (ctrl.ldb_inv_db) begin
            b = ~db_in;
        end else if (ctrl.ldb_db) begin
            b = db_in;
        end else begin
            b = '0;
        end
    end

    assign bin_sum = {1'b0, a} + {1'b0, b} + {{data_w{1'b0}}, ctrl.carry_in};

    // same-sign operands producing a result of the other sign
    assign overflow = (a[data_w-1] == b[data_w-1]) && (bin_sum[data_w-1] != a[data_w-1]);

    // inverted db on b means a subtract
    assign dec_sub = ctrl.ldb_inv_db;

    always_comb begin
        lo_raw = {1'b0, a[nib_w-1:0]} + {1'b0, b[nib_w-1:0]}
               + {{nib_w{1'b0}}, ctrl.carry_in};
        if (dec_sub) begin
            lo_carry = lo_raw[nib_w];                   // set means no borrow
            lo_adj   = lo_carry ? lo_raw[nib_w-1:0] : lo_raw[nib_w-1:0] - bcd_adj;
        end else begin
            lo_carry = lo_raw > {1'b0, bcd_max};
            lo_adj   = lo_carry ? lo_raw[nib_w-1:0] + bcd_adj : lo_raw[nib_w-1:0];
        end

        hi_raw = {1'b0, a[data_w-1:nib_w]} + {1'b0, b[data_w-1:nib_w]}
               + {{nib_w{1'b0}}, lo_carry};
        if (dec_sub) begin
            dec_carry = hi_raw[nib_w];
            hi_adj    = dec_carry ? hi_raw[nib_w-1:0] : hi_raw[nib_w-1:0] - bcd_adj;
        end else begin
            dec_carry = hi_raw > {1'b0, bcd_max};
            hi_adj    = dec_carry ? hi_raw[nib_w-1:0] + bcd_adj : hi_raw[nib_w-1:0];
        end
    end

    always_comb begin
        alu_out   = '0;
        carry_out = 1'b0;
        if (ctrl.e_sum) begin
            if (ctrl.enable_dec) begin
                alu_out   = {hi_adj, lo_adj};
                carry_out = dec_carry;
            end else begin
                alu_out   = bin_sum[data_w-1:0];
                carry_out = bin_sum[data_w];
            end
        end else if (ctrl.e_and) begin
            alu_out = a & b;
        end else if (ctrl.e_eor) begin
            alu_out = a ^ b;
        end else if (ctrl.e_or) begin
            alu_out = a | b;
        end else if (ctrl.e_shiftr) begin
            alu_out   = {ctrl.carry_in, a[data_w-1:1]};  // carry_in enters at the top
            carry_out = a[0];
        end
    end

    // a zero operand must win cleanly, never fight the accumulator
    a_sel_excl: assert property (@(posedge clk) !(ctrl.lda_sb && ctrl.lda_zero))
        else $error("alu: lda_sb and lda_zero both high");

endmodule

// File: verilog/alu_regs.sv
module alu_regs (
    input  logic                        clk,
    input  logic                        reset,
    alu_ctrl_if.regs                    ctrl,
    input  logic [alu_pkg::data_w-1:0]  alu_out,
    input  logic                        carry_out,
    input  logic                        overflow,
    output logic [alu_pkg::data_w-1:0]  acc,
    output logic [alu_pkg::flags_w-1:0] flags,
    output logic                        result_valid
);
    import alu_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (ctrl.acc_we) begin
            acc <= alu_out;                             // also feeds sb next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else begin
            if (ctrl.upd_nz) begin
                flags[flag_n] <= alu_out[data_w-1];
                flags[flag_z] <= (alu_out == '0);
            end
            if (ctrl.upd_c) begin
                flags[flag_c] <= carry_out;
            end
            if (ctrl.upd_v) begin
                flags[flag_v] <= overflow;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= ctrl.op_done;               // one cycle after issue
        end
    end

    // no stale pulse may leak out of reset
    rv_after_reset: assert property (@(posedge clk) reset |=> !result_valid)
        else $error("alu_regs: result_valid high right after reset");

    // register writes only come from an issued operation
    we_needs_op: assert property (@(posedge clk) disable iff (reset)
        (ctrl.acc_we || ctrl.upd_nz || ctrl.upd_c || ctrl.upd_v) |-> ctrl.op_done)
        else $error("alu_regs: register update without an issued operation");

endmodule

// File: verilog/alu_datapath.sv
module alu_datapath (
    input  logic                        clk,
    input  logic                        reset,
    input  alu_pkg::alu_op_t            op,
    input  logic                        op_valid,
    input  logic [alu_pkg::data_w-1:0]  db,
    input  logic [alu_pkg::data_w-1:0]  adl,
    input  logic                        d_flag,
    output logic [alu_pkg::data_w-1:0]  acc,
    output logic [alu_pkg::flags_w-1:0] flags,
    output logic                        result_valid
);
    import alu_pkg::*;

    logic [data_w-1:0] alu_out;
    logic              carry_out;
    logic              overflow;

    alu_ctrl_if ctrl_bus ();

    alu_decoder decoder0 (
        .op       (op),
        .op_valid (op_valid),
        .d_flag   (d_flag),
        .c_flag   (flags[flag_c]),                      // live carry for adc/sbc/ror
        .ctrl     (ctrl_bus.decoder)
    );

    alu alu0 (
        .clk       (clk),
        .ctrl      (ctrl_bus.alu),
        .db_in     (db),
        .adl_in    (adl),
        .sb_in     (acc),                               // accumulator drives sb
        .alu_out   (alu_out),
        .carry_out (carry_out),
        .overflow  (overflow)
    );

    alu_regs regs0 (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl_bus.regs),
        .alu_out      (alu_out),
        .carry_out    (carry_out),
        .overflow     (overflow),
        .acc          (acc),
        .flags        (flags),
        .result_valid (result_valid)
    );

endmodule

// File: tests/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// bcd add, returns {carry, result}
function automatic logic [8:0] bcd_add(logic [7:0] a, logic [7:0] b, logic c);
    int   lo;
    int   hi;
    logic lo_c;
    logic hi_c;
    lo   = int'(a[3:0]) + int'(b[3:0]) + int'(c);
    lo_c = (lo > 9);
    if (lo_c) lo = lo + 6;                          // skip the six non-decimal codes
    hi   = int'(a[7:4]) + int'(b[7:4]) + int'(lo_c);
    hi_c = (hi > 9);
    if (hi_c) hi = hi + 6;
    return {hi_c, 4'(hi), 4'(lo)};
endfunction

// bcd subtract a - b - !c, returns {no_borrow, result}
function automatic logic [8:0] bcd_sub(logic [7:0] a, logic [7:0] b, logic c);
    int   lo;
    int   hi;
    logic lo_b;
    logic hi_b;
    lo   = int'(a[3:0]) - int'(b[3:0]) - (c ? 0 : 1);
    lo_b = (lo < 0);
    if (lo_b) lo = lo - 6;                          // borrowing digit drops six
    hi   = int'(a[7:4]) - int'(b[7:4]) - int'(lo_b);
    hi_b = (hi < 0);
    if (hi_b) hi = hi - 6;
    return {!hi_b, 4'(hi), 4'(lo)};
endfunction

// expected {flags, acc} after one operation
function automatic logic [11:0] model_step(alu_op_t op, logic d, logic [7:0] a,
                                           logic [3:0] f, logic [7:0] db_v,
                                           logic [7:0] adl_v);
    logic [3:0] nf;
    logic [7:0] res;
    logic [7:0] nz;
    logic [7:0] b;
    logic       c;
    int         t;
    nf  = f;
    res = a;
    case (op)
        op_lda: res = db_v;
        op_adc, op_adc_adl: begin
            b = (op == op_adc) ? db_v : adl_v;
            if (d && op == op_adc) begin
                {c, res} = bcd_add(a, b, f[flag_c]);    // v keeps its old value
            end else begin
                t   = int'(a) + int'(b) + int'(f[flag_c]);
                res = 8'(t);
                c   = (t > 255);
                nf[flag_v] = (a[7] == b[7]) && (res[7] != a[7]);
            end
            nf[flag_c] = c;
        end
        op_sbc: begin
            if (d) begin
                {c, res} = bcd_sub(a, db_v, f[flag_c]);
            end else begin
                t   = int'(a) - int'(db_v) - (f[flag_c] ? 0 : 1);
                res = 8'(t);
                c   = (t >= 0);                         // carry means no borrow
                nf[flag_v] = (a[7] != db_v[7]) && (res[7] != a[7]);
            end
            nf[flag_c] = c;
        end
        op_and: res = a & db_v;
        op_ora: res = a | db_v;
        op_eor: res = a ^ db_v;
        op_lsr: begin
            res        = {1'b0, a[7:1]};
            nf[flag_c] = a[0];
        end
        op_ror: begin
            res        = {f[flag_c], a[7:1]};
            nf[flag_c] = a[0];
        end
        default: ;
    endcase
    nz = res;
    if (op == op_cmp) begin
        t          = int'(a) - int'(db_v);
        nz         = 8'(t);                             // acc itself stays put
        nf[flag_c] = (t >= 0);
    end
    nf[flag_n] = nz[7];
    nf[flag_z] = (nz == 8'h00);
    return {nf, res};
endfunction

`endif

// File: tests/alu_datapath_tb.sv
module alu_datapath_tb;
    import alu_pkg::*;

    `include "alu_model.svh"

    localparam int reset_cycles = 5;
    localparam int ops_per_test = 64;
    localparam int max_cycles   = 700;                  // six tests of ~64 ops plus reset

    logic        clk;
    logic        reset;
    alu_op_t     op;
    logic        op_valid;
    logic [7:0]  db;
    logic [7:0]  adl;
    logic        d_flag;
    logic [7:0]  acc;
    logic [3:0]  flags;
    logic        result_valid;

    logic [7:0]  mirror_acc   = 8'h00;                  // state after every issued op
    logic [3:0]  mirror_flags = 4'h0;
    logic [7:0]  exp_acc      = 8'h00;                  // mirror one edge later
    logic [3:0]  exp_flags    = 4'h0;
    int          errors            = 0;
    int          test_start_errors = 0;
    int          tests_run         = 0;
    int          ops_issued        = 0;
    int          cycle_cnt         = 0;

    alu_datapath dut0 (
        .clk          (clk),
        .reset        (reset),
        .op           (op),
        .op_valid     (op_valid),
        .db           (db),
        .adl          (adl),
        .d_flag       (d_flag),
        .acc          (acc),
        .flags        (flags),
        .result_valid (result_valid)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        exp_acc   <= mirror_acc;                        // lines up with result_valid
        exp_flags <= mirror_flags;
    end

    acc_check: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> (acc == exp_acc))
        else begin
            errors++;
            $display("Mismatch acc: got %h, expected %h", $sampled(acc), $sampled(exp_acc));
        end

    flags_check: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> (flags == exp_flags))
        else begin
            errors++;
            $display("Mismatch flags: got %h, expected %h",
                     $sampled(flags), $sampled(exp_flags));
        end

    valid_check: assert property (@(posedge clk) disable iff (reset)
        result_valid == $past(op_valid))
        else begin
            errors++;
            $display("result_valid did not follow op_valid by exactly one cycle");
        end

    initial begin
        wait (cycle_cnt >= max_cycles);
        $display("run stopped after %0d cycles without finishing", max_cycles);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [7:0] rand_byte();
        return 8'($urandom);
    endfunction

    function automatic logic [7:0] rand_bcd();
        return {4'($urandom % 10), 4'($urandom % 10)};
    endfunction

    task automatic issue(alu_op_t o, logic [7:0] db_v, logic [7:0] adl_v, logic dec);
        logic [11:0] nxt;
        @(posedge clk);
        #1;
        op       = o;
        db       = db_v;
        adl      = adl_v;
        d_flag   = dec;
        op_valid = 1'b1;
        nxt = model_step(o, dec, mirror_acc, mirror_flags, db_v, adl_v);
        {mirror_flags, mirror_acc} = nxt;
        ops_issued++;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            op_valid = 1'b0;
        end
    endtask

    task automatic check_value(string name, logic [7:0] got, logic [7:0] want);
        assert (got == want) else begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic finish_test(string name);
        idle(2);                                        // let the last result be checked
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    initial begin
        logic [7:0] start_val;
        logic [7:0] first_val;
        logic       start_c;
        int         k;

        void'($urandom(32'hffab));
        reset    = 1'b1;
        op       = op_lda;
        op_valid = 1'b0;
        db       = 8'h00;
        adl      = 8'h00;
        d_flag   = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset state and loads
        check_value("result_valid", 8'(result_valid), 8'h00);
        check_value("acc", acc, 8'h00);
        check_value("flags", 8'(flags), 8'h00);
        issue(op_lda, 8'h00, 8'h5a, 1'b0);
        idle(1);
        check_value("flags.z", 8'(flags[flag_z]), 8'h01);
        issue(op_lda, 8'h80, 8'h00, 1'b0);
        idle(1);
        check_value("flags.n", 8'(flags[flag_n]), 8'h01);
        finish_test("reset and load");

        // binary arithmetic
        repeat (ops_per_test) begin
            k = int'($urandom % 3);
            case (k)
                0: issue(op_adc, rand_byte(), rand_byte(), 1'b0);
                1: issue(op_sbc, rand_byte(), rand_byte(), 1'b0);
                default: issue(op_adc_adl, rand_byte(), rand_byte(), 1'b0);
            endcase
        end
        finish_test("binary arithmetic");

        // decimal arithmetic on valid bcd
        repeat (ops_per_test / 2) begin
            issue(op_lda, rand_bcd(), rand_byte(), 1'b1);
            if ($urandom % 2 == 0) issue(op_adc, rand_bcd(), rand_byte(), 1'b1);
            else issue(op_sbc, rand_bcd(), rand_byte(), 1'b1);
        end
        finish_test("decimal arithmetic");

        // logic operations
        issue(op_lda, 8'h80, 8'h00, 1'b0);
        issue(op_adc, 8'h80, 8'h00, 1'b0);              // c and v both end up set
        repeat (ops_per_test / 4) begin
            issue(op_lda, rand_byte(), rand_byte(), 1'b0);
            issue(op_and, rand_byte(), rand_byte(), 1'b0);
            issue(op_ora, rand_byte(), rand_byte(), 1'b0);
            issue(op_eor, rand_byte(), rand_byte(), 1'b0);
        end
        finish_test("logic");

        // shifts and a full 9-step rotate through carry
        repeat (13) begin
            issue(op_lda, rand_byte(), rand_byte(), 1'b0);
            issue(op_lsr, rand_byte(), rand_byte(), 1'b0);
            issue(op_ror, rand_byte(), rand_byte(), 1'b0);
            issue(op_ror, rand_byte(), rand_byte(), 1'b0);
        end
        start_val = rand_byte();
        issue(op_lda, start_val, 8'h00, 1'b0);
        start_c = mirror_flags[flag_c];
        repeat (9) issue(op_ror, rand_byte(), rand_byte(), 1'b0);
        idle(1);
        check_value("acc after 9 ror", acc, start_val);
        check_value("flags.c after 9 ror", 8'(flags[flag_c]), 8'(start_c));
        finish_test("shift and rotate");

        // compare and then any op every cycle
        first_val = rand_byte();
        issue(op_lda, first_val, 8'h00, 1'b0);
        issue(op_cmp, rand_byte(), 8'h00, 1'b0);
        idle(1);
        check_value("acc after cmp", acc, first_val);
        repeat (15) begin
            issue(op_lda, rand_byte(), rand_byte(), 1'b0);
            issue(op_cmp, rand_byte(), rand_byte(), 1'b0);
        end
        repeat (ops_per_test / 2) begin
            issue(alu_op_t'(4'($urandom % 10)), rand_byte(), rand_byte(), 1'($urandom));
        end
        finish_test("compare and back-to-back");

        $display("tests %0d, operations %0d, errors %0d", tests_run, ops_issued, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+tests
verilog/alu_pkg.sv
verilog/alu_ctrl_if.sv
verilog/alu_decoder.sv
verilog/alu.sv
verilog/alu_regs.sv
verilog/alu_datapath.sv
tests/alu_datapath_tb.sv

// File: Makefile
TOP = alu_datapath_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f build.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@if grep -q "^>>> PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
